// ==== Makefile ====
# Verilator flow for the trail subsystem
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= trail_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
PASS_MSG  ?= Simulation finished: PASS

VFLAGS ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
src/trail_pkg.sv
src/trail_classifier.sv
src/trail_grid.sv
src/tile_writer.sv
src/trail_top.sv
test/trail_tb.sv

// ==== src/tile_writer.sv ====
/*
 * stage 3: paints one 8x8 trail tile per event into the frame buffer
 * rows go out on eight back-to-back cycles, the credit returns with the last
 */
`timescale 1ns/10ps

module tile_writer (
	input  logic                Clk,
	input  logic                arst_n,
	input  logic                run,
	input  logic                evt_valid,
	input  trail_pkg::player_t  evt_player,
	input  trail_pkg::coord_t   evt_x,
	input  trail_pkg::coord_t   evt_y,
	input  trail_pkg::kind_t    evt_kind,
	output logic                evt_credit,
	output logic                fb_we,
	output trail_pkg::fb_addr_t fb_addr,
	output trail_pkg::fb_word_t fb_data
);

	localparam int PIXELS = $bits(trail_pkg::fb_word_t) / $bits(trail_pkg::pix_t);

	typedef enum logic {
		IDLE,
		PAINT
	} state_t;

	state_t state;
	logic [2:0] row;
	logic last_row;
	logic horiz_on;
	logic vert_on;
	trail_pkg::pix_t color;

	trail_pkg::player_t cur_player;
	trail_pkg::coord_t  cur_x;
	trail_pkg::coord_t  cur_y;
	trail_pkg::kind_t   cur_kind;

	assign last_row   = (row == 3'(trail_pkg::TILE_ROWS - 1));
	assign fb_we      = (state == PAINT);
	assign evt_credit = (state == PAINT) && last_row;

	// word address of row r is (y*8 + r)*32 + x
	assign fb_addr = trail_pkg::fb_addr_t'((cur_y * trail_pkg::TILE_ROWS + row)
		* trail_pkg::GRID_W + cur_x);

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= IDLE;
			row   <= 3'd0;
		end
		else if (!run)
		begin
			state <= IDLE;
			row   <= 3'd0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					row <= 3'd0;
					if (evt_valid)
						state <= PAINT;
				end
				PAINT:
				begin
					row <= row + 3'd1;
					if (last_row)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// hold the accepted event for the whole tile
	always_ff @(posedge Clk)
	begin
		if (state == IDLE && evt_valid)
		begin
			cur_player <= evt_player;
			cur_x      <= evt_x;
			cur_y      <= evt_y;
			cur_kind   <= evt_kind;
		end
	end

	// corner is the union of both strokes
	assign horiz_on = (cur_kind != trail_pkg::KIND_VERT) && (row == 3'd3 || row == 3'd4);
	assign vert_on  = (cur_kind != trail_pkg::KIND_HORIZ);

	always_comb
	begin
		color = (cur_player == trail_pkg::PLAYER_RED) ? trail_pkg::PIX_RED : trail_pkg::PIX_BLUE;
		fb_data = {PIXELS{trail_pkg::PIX_EMPTY}};
		for (int p = 0; p < PIXELS; p++)
		begin
			if (horiz_on || (vert_on && (p == 3 || p == 4)))
				fb_data[2*p +: 2] = color;
		end
	end

	// the grid only forwards once the previous tile returned its credit
	assert property (@(posedge Clk) disable iff (!arst_n) evt_valid |-> (state == IDLE));

endmodule

// ==== src/trail_classifier.sv ====
/*
 * stage 1: samples both cycles on each frame tick and turns moves into trail events
 * events leave blue first, one per cycle, as long as downstream credits remain
 */
`timescale 1ns/10ps

module trail_classifier #(
	parameter int EVT_CREDITS = 2
) (
	input  logic                Clk,
	input  logic                arst_n,
	input  logic                run,
	input  logic                frame_tick,
	input  trail_pkg::coord_t   blue_x,
	input  trail_pkg::coord_t   blue_y,
	input  trail_pkg::dir_t     blue_dir,
	input  trail_pkg::coord_t   red_x,
	input  trail_pkg::coord_t   red_y,
	input  trail_pkg::dir_t     red_dir,
	output logic                evt_valid,
	output trail_pkg::player_t  evt_player,
	output trail_pkg::coord_t   evt_x,
	output trail_pkg::coord_t   evt_y,
	output trail_pkg::kind_t    evt_kind,
	input  logic                evt_credit
);

	localparam int CNT_W = $clog2(EVT_CREDITS + 1);

	logic             armed;
	logic             take_tick;
	logic             blue_moved;
	logic             red_moved;
	logic [1:0]       pend_cnt;
	logic [CNT_W-1:0] credit_cnt;

	trail_pkg::coord_t last_blue_x;
	trail_pkg::coord_t last_blue_y;
	trail_pkg::coord_t last_red_x;
	trail_pkg::coord_t last_red_y;
	trail_pkg::dir_t   last_blue_dir;
	trail_pkg::dir_t   last_red_dir;

	// two-entry pending queue, head at index 0
	trail_pkg::player_t q_player [2];
	trail_pkg::coord_t  q_x [2];
	trail_pkg::coord_t  q_y [2];
	trail_pkg::kind_t   q_kind [2];

	function automatic trail_pkg::kind_t classify(input trail_pkg::dir_t dir,
		input trail_pkg::dir_t last_dir);
		trail_pkg::kind_t kind;
		if (dir != last_dir)
			kind = trail_pkg::KIND_CORNER;
		else if (dir == trail_pkg::DIR_UP || dir == trail_pkg::DIR_DOWN)
			kind = trail_pkg::KIND_VERT;
		else
			kind = trail_pkg::KIND_HORIZ;
		return kind;
	endfunction

	// a tick while events are still queued is dropped
	assign take_tick  = run && frame_tick && (pend_cnt == 2'd0);
	assign blue_moved = armed && ((blue_x != last_blue_x) || (blue_y != last_blue_y));
	assign red_moved  = armed && ((red_x != last_red_x) || (red_y != last_red_y));

	assign evt_valid  = (pend_cnt != 2'd0) && (credit_cnt != '0);
	assign evt_player = q_player[0];
	assign evt_x      = q_x[0];
	assign evt_y      = q_y[0];
	assign evt_kind   = q_kind[0];

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			armed    <= 1'b0;
			pend_cnt <= 2'd0;
		end
		else if (!run)
		begin
			armed    <= 1'b0;
			pend_cnt <= 2'd0;
		end
		else if (take_tick)
		begin
			armed    <= 1'b1;
			pend_cnt <= {1'b0, blue_moved} + {1'b0, red_moved};
		end
		else if (evt_valid)
			pend_cnt <= pend_cnt - 2'd1;
	end

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
			credit_cnt <= CNT_W'(EVT_CREDITS);
		else if (!run)
			credit_cnt <= CNT_W'(EVT_CREDITS);
		else if (evt_valid && !evt_credit)
			credit_cnt <= credit_cnt - 1'b1;
		else if (!evt_valid && evt_credit)
			credit_cnt <= credit_cnt + 1'b1;
	end

	// samples and queue payload
	always_ff @(posedge Clk)
	begin
		if (take_tick)
		begin
			last_blue_x   <= blue_x;
			last_blue_y   <= blue_y;
			last_blue_dir <= blue_dir;
			last_red_x    <= red_x;
			last_red_y    <= red_y;
			last_red_dir  <= red_dir;
			// red lands behind blue, or at the head when blue stood still
			if (blue_moved)
			begin
				q_player[0] <= trail_pkg::PLAYER_BLUE;
				q_x[0]      <= blue_x;
				q_y[0]      <= blue_y;
				q_kind[0]   <= classify(blue_dir, last_blue_dir);
				q_player[1] <= trail_pkg::PLAYER_RED;
				q_x[1]      <= red_x;
				q_y[1]      <= red_y;
				q_kind[1]   <= classify(red_dir, last_red_dir);
			end
			else
			begin
				q_player[0] <= trail_pkg::PLAYER_RED;
				q_x[0]      <= red_x;
				q_y[0]      <= red_y;
				q_kind[0]   <= classify(red_dir, last_red_dir);
			end
		end
		else if (evt_valid)
		begin
			q_player[0] <= q_player[1];
			q_x[0]      <= q_x[1];
			q_y[0]      <= q_y[1];
			q_kind[0]   <= q_kind[1];
		end
	end

	// returned credits must never exceed what was handed out
	assert property (@(posedge Clk) disable iff (!arst_n) credit_cnt <= CNT_W'(EVT_CREDITS));

endmodule

// ==== src/trail_grid.sv ====
/*
 * second pipeline stage that buffers classifier events and keeps the occupancy grid
 * each event tests and marks its cell, then goes on to the tile writer
 */
`timescale 1ns/10ps

module trail_grid #(
	parameter int EVT_CREDITS = 2,
	parameter int WR_CREDITS  = 1
) (
	input  logic                Clk,
	input  logic                arst_n,
	input  logic                run,
	input  logic                evt_valid,
	input  trail_pkg::player_t  evt_player,
	input  trail_pkg::coord_t   evt_x,
	input  trail_pkg::coord_t   evt_y,
	input  trail_pkg::kind_t    evt_kind,
	output logic                evt_credit,
	output logic                fwd_valid,
	output trail_pkg::player_t  fwd_player,
	output trail_pkg::coord_t   fwd_x,
	output trail_pkg::coord_t   fwd_y,
	output trail_pkg::kind_t    fwd_kind,
	input  logic                wr_credit,
	output logic                crash_blue,
	output logic                crash_red
);

	localparam int PTR_W    = (EVT_CREDITS > 1) ? $clog2(EVT_CREDITS) : 1;
	localparam int CNT_W    = $clog2(EVT_CREDITS + 1);
	localparam int WR_CNT_W = $clog2(WR_CREDITS + 1);

	trail_pkg::player_t buf_player [EVT_CREDITS];
	trail_pkg::coord_t  buf_x [EVT_CREDITS];
	trail_pkg::coord_t  buf_y [EVT_CREDITS];
	trail_pkg::kind_t   buf_kind [EVT_CREDITS];

	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    buf_cnt;
	logic [WR_CNT_W-1:0] wr_cnt;
	logic                hit;

	// one bit per cell indexed by [y][x]
	logic [trail_pkg::GRID_H-1:0][trail_pkg::GRID_W-1:0] occ;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(EVT_CREDITS - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign fwd_valid  = (buf_cnt != '0) && (wr_cnt != '0);
	assign fwd_player = buf_player[rd_ptr];
	assign fwd_x      = buf_x[rd_ptr];
	assign fwd_y      = buf_y[rd_ptr];
	assign fwd_kind   = buf_kind[rd_ptr];
	assign hit        = occ[fwd_y][fwd_x];

	// forwarding frees the slot
	assign evt_credit = fwd_valid;

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			buf_cnt <= '0;
		end
		else if (!run)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			buf_cnt <= '0;
		end
		else
		begin
			if (evt_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (fwd_valid)
				rd_ptr <= ptr_next(rd_ptr);
			if (evt_valid && !fwd_valid)
				buf_cnt <= buf_cnt + 1'b1;
			else if (!evt_valid && fwd_valid)
				buf_cnt <= buf_cnt - 1'b1;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (evt_valid)
		begin
			buf_player[wr_ptr] <= evt_player;
			buf_x[wr_ptr]      <= evt_x;
			buf_y[wr_ptr]      <= evt_y;
			buf_kind[wr_ptr]   <= evt_kind;
		end
	end

	// writer credits
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
			wr_cnt <= WR_CNT_W'(WR_CREDITS);
		else if (!run)
			wr_cnt <= WR_CNT_W'(WR_CREDITS);
		else if (fwd_valid && !wr_credit)
			wr_cnt <= wr_cnt - 1'b1;
		else if (!fwd_valid && wr_credit)
			wr_cnt <= wr_cnt + 1'b1;
	end

	// crash flags stick until run drops
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			occ        <= '0;
			crash_blue <= 1'b0;
			crash_red  <= 1'b0;
		end
		else if (!run)
		begin
			occ        <= '0;
			crash_blue <= 1'b0;
			crash_red  <= 1'b0;
		end
		else if (fwd_valid)
		begin
			occ[fwd_y][fwd_x] <= 1'b1;
			if (hit && fwd_player == trail_pkg::PLAYER_RED)
				crash_red <= 1'b1;
			if (hit && fwd_player == trail_pkg::PLAYER_BLUE)
				crash_blue <= 1'b1;
		end
	end

	// the classifier's credit count must keep it from overrunning the buffer
	assert property (@(posedge Clk) disable iff (!arst_n)
		evt_valid |-> (buf_cnt < CNT_W'(EVT_CREDITS)));

endmodule

// ==== src/trail_pkg.sv ====
/*
 * shared types and constants for the light-cycle trail subsystem
 * every stage refers to these through trail_pkg:: scoped names
 */
package trail_pkg;

	// play field in cells
	localparam int GRID_W = 32;
	localparam int GRID_H = 32;

	// one tile is eight frame buffer words, one per pixel row
	localparam int TILE_ROWS = 8;

	typedef logic [4:0] coord_t;

	typedef enum logic [1:0] {
		DIR_UP,
		DIR_DOWN,
		DIR_LEFT,
		DIR_RIGHT
	} dir_t;

	typedef enum logic [1:0] {
		KIND_HORIZ,
		KIND_VERT,
		KIND_CORNER
	} kind_t;

	typedef logic player_t;

	localparam player_t PLAYER_BLUE = 1'b0;
	localparam player_t PLAYER_RED  = 1'b1;

	// 2-bit pixel codes, pixel 0 sits in the lowest bits of a word
	typedef logic [1:0] pix_t;

	localparam pix_t PIX_EMPTY = 2'b00;
	localparam pix_t PIX_BLUE  = 2'b01;
	localparam pix_t PIX_RED   = 2'b10;

	typedef logic [12:0] fb_addr_t;
	typedef logic [15:0] fb_word_t;

endpackage

// ==== src/trail_top.sv ====
/*
 * trail subsystem top: classifier, occupancy grid and tile writer in a chain
 * links between stages are credit controlled, depths set here
 */
`timescale 1ns/10ps

module trail_top #(
	parameter int EVT_CREDITS = 2,
	parameter int WR_CREDITS  = 1
) (
	input  logic                Clk,
	input  logic                arst_n,
	input  logic                run,
	input  logic                frame_tick,
	input  trail_pkg::coord_t   blue_x,
	input  trail_pkg::coord_t   blue_y,
	input  trail_pkg::dir_t     blue_dir,
	input  trail_pkg::coord_t   red_x,
	input  trail_pkg::coord_t   red_y,
	input  trail_pkg::dir_t     red_dir,
	output logic                fb_we,
	output trail_pkg::fb_addr_t fb_addr,
	output trail_pkg::fb_word_t fb_data,
	output logic                crash_blue,
	output logic                crash_red
);

	// classifier to grid
	logic               cls_valid;
	trail_pkg::player_t cls_player;
	trail_pkg::coord_t  cls_x;
	trail_pkg::coord_t  cls_y;
	trail_pkg::kind_t   cls_kind;
	logic               cls_credit;

	// grid to writer
	logic               grd_valid;
	trail_pkg::player_t grd_player;
	trail_pkg::coord_t  grd_x;
	trail_pkg::coord_t  grd_y;
	trail_pkg::kind_t   grd_kind;
	logic               grd_credit;

	trail_classifier #(
		.EVT_CREDITS(EVT_CREDITS)
	) i_trail_classifier (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.run        (run),
		.frame_tick (frame_tick),
		.blue_x     (blue_x),
		.blue_y     (blue_y),
		.blue_dir   (blue_dir),
		.red_x      (red_x),
		.red_y      (red_y),
		.red_dir    (red_dir),
		.evt_valid  (cls_valid),
		.evt_player (cls_player),
		.evt_x      (cls_x),
		.evt_y      (cls_y),
		.evt_kind   (cls_kind),
		.evt_credit (cls_credit)
	);

	trail_grid #(
		.EVT_CREDITS(EVT_CREDITS),
		.WR_CREDITS (WR_CREDITS)
	) i_trail_grid (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.run        (run),
		.evt_valid  (cls_valid),
		.evt_player (cls_player),
		.evt_x      (cls_x),
		.evt_y      (cls_y),
		.evt_kind   (cls_kind),
		.evt_credit (cls_credit),
		.fwd_valid  (grd_valid),
		.fwd_player (grd_player),
		.fwd_x      (grd_x),
		.fwd_y      (grd_y),
		.fwd_kind   (grd_kind),
		.wr_credit  (grd_credit),
		.crash_blue (crash_blue),
		.crash_red  (crash_red)
	);

	tile_writer i_tile_writer (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.run        (run),
		.evt_valid  (grd_valid),
		.evt_player (grd_player),
		.evt_x      (grd_x),
		.evt_y      (grd_y),
		.evt_kind   (grd_kind),
		.evt_credit (grd_credit),
		.fb_we      (fb_we),
		.fb_addr    (fb_addr),
		.fb_data    (fb_data)
	);

endmodule

// ==== test/trail_tb.sv ====
/*
 * directed testbench for the trail subsystem
 * moves both cycles frame by frame, checks tile writes and crash flags
 */
`timescale 1ns/10ps

module trail_tb;

	localparam int TIMEOUT = 200;
	localparam int SETTLE  = 12;

	logic Clk;
	logic arst_n;
	logic run;
	logic frame_tick;
	trail_pkg::coord_t blue_x;
	trail_pkg::coord_t blue_y;
	trail_pkg::dir_t   blue_dir;
	trail_pkg::coord_t red_x;
	trail_pkg::coord_t red_y;
	trail_pkg::dir_t   red_dir;
	logic fb_we;
	trail_pkg::fb_addr_t fb_addr;
	trail_pkg::fb_word_t fb_data;
	logic crash_blue;
	logic crash_red;

	logic [7:0] lfsr;
	logic [28:0] wr_q [$];

	// expected state of the subsystem, index 0 is blue and 1 is red
	logic occupied [trail_pkg::GRID_W * trail_pkg::GRID_H];
	logic armed;
	logic exp_crash [2];
	trail_pkg::coord_t last_x [2];
	trail_pkg::coord_t last_y [2];
	trail_pkg::dir_t   last_dir [2];

	trail_top #(
		.EVT_CREDITS(2),
		.WR_CREDITS (1)
	) i_trail_top (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.run        (run),
		.frame_tick (frame_tick),
		.blue_x     (blue_x),
		.blue_y     (blue_y),
		.blue_dir   (blue_dir),
		.red_x      (red_x),
		.red_y      (red_y),
		.red_dir    (red_dir),
		.fb_we      (fb_we),
		.fb_addr    (fb_addr),
		.fb_data    (fb_data),
		.crash_blue (crash_blue),
		.crash_red  (crash_red)
	);

	initial
		Clk = 1'b0;
	always
		#50 Clk = ~Clk;

	// outputs come from registers only, so the falling edge sees them settled
	always @(negedge Clk)
	begin
		if (arst_n && fb_we)
			wr_q.push_back({fb_addr, fb_data});
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_fb_addr(input string test, input trail_pkg::fb_addr_t exp,
		input trail_pkg::fb_addr_t act);
		if (exp !== act)
			report_failure($sformatf("CHECK FAILED %s fb_addr expected %0d actual %0d",
				test, exp, act));
	endtask

	task automatic check_fb_word(input string test, input trail_pkg::fb_word_t exp,
		input trail_pkg::fb_word_t act);
		if (exp !== act)
			report_failure($sformatf("CHECK FAILED %s fb_data expected %h actual %h",
				test, exp, act));
	endtask

	task automatic check_crash(input string test, input logic exp, input logic act);
		if (exp !== act)
			report_failure($sformatf("CHECK FAILED %s crash expected %b actual %b",
				test, exp, act));
	endtask

	// taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic rand_coord(output trail_pkg::coord_t c);
		for (int i = 0; i < 5; i++)
		begin
			lfsr = lfsr_next(lfsr);
			c[i] = lfsr[0];
		end
	endtask

	// pixels 3 and 4 sit at bits 7:6 and 9:8
	function automatic trail_pkg::fb_word_t tile_row(input int p, input trail_pkg::kind_t kind,
		input int r);
		trail_pkg::fb_word_t w;
		logic [1:0] c;
		c = (p == 1) ? 2'b10 : 2'b01;
		w = '0;
		if (kind != trail_pkg::KIND_VERT && (r == 3 || r == 4))
			w = {8{c}};
		if (kind != trail_pkg::KIND_HORIZ)
		begin
			w[7:6] = c;
			w[9:8] = c;
		end
		return w;
	endfunction

	function automatic trail_pkg::fb_addr_t row_addr(input trail_pkg::coord_t x,
		input trail_pkg::coord_t y, input int r);
		return trail_pkg::fb_addr_t'((int'(y) * 8 + r) * 32 + int'(x));
	endfunction

	task automatic set_run(input logic value);
		@(negedge Clk);
		run = value;
		if (!value)
		begin
			armed = 1'b0;
			exp_crash[0] = 1'b0;
			exp_crash[1] = 1'b0;
			foreach (occupied[i])
				occupied[i] = 1'b0;
		end
		@(negedge Clk);
	endtask

	// one frame tick, then every expected tile is checked row by row
	task automatic frame(input string test);
		trail_pkg::coord_t nx [2];
		trail_pkg::coord_t ny [2];
		trail_pkg::dir_t   nd [2];
		trail_pkg::kind_t  kind [2];
		logic moved [2];
		logic [28:0] entry;
		int n_exp;
		int cycles;
		nx[0] = blue_x;
		ny[0] = blue_y;
		nd[0] = blue_dir;
		nx[1] = red_x;
		ny[1] = red_y;
		nd[1] = red_dir;
		n_exp = 0;
		for (int p = 0; p < 2; p++)
		begin
			moved[p] = armed && (nx[p] != last_x[p] || ny[p] != last_y[p]);
			if (nd[p] != last_dir[p])
				kind[p] = trail_pkg::KIND_CORNER;
			else if (nd[p] == trail_pkg::DIR_UP || nd[p] == trail_pkg::DIR_DOWN)
				kind[p] = trail_pkg::KIND_VERT;
			else
				kind[p] = trail_pkg::KIND_HORIZ;
			if (moved[p])
				n_exp += trail_pkg::TILE_ROWS;
		end
		@(negedge Clk);
		frame_tick = 1'b1;
		@(negedge Clk);
		frame_tick = 1'b0;
		cycles = 0;
		while (wr_q.size() < n_exp)
		begin
			@(negedge Clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure($sformatf("%s: only %0d of %0d frame buffer writes arrived",
					test, wr_q.size(), n_exp));
		end
		// extra writes would show up within this window
		repeat (SETTLE) @(negedge Clk);
		if (wr_q.size() != n_exp)
			report_failure($sformatf("%s: %0d frame buffer writes seen, %0d expected",
				test, wr_q.size(), n_exp));
		for (int p = 0; p < 2; p++)
		begin
			if (moved[p])
			begin
				for (int r = 0; r < trail_pkg::TILE_ROWS; r++)
				begin
					entry = wr_q.pop_front();
					check_fb_addr(test, row_addr(nx[p], ny[p], r), entry[28:16]);
					check_fb_word(test, tile_row(p, kind[p], r), entry[15:0]);
				end
				if (occupied[int'(ny[p]) * 32 + int'(nx[p])])
					exp_crash[p] = 1'b1;
				occupied[int'(ny[p]) * 32 + int'(nx[p])] = 1'b1;
			end
			last_x[p] = nx[p];
			last_y[p] = ny[p];
			last_dir[p] = nd[p];
		end
		armed = 1'b1;
		check_crash(test, exp_crash[0], crash_blue);
		check_crash(test, exp_crash[1], crash_red);
	endtask

	task automatic restart(input string test);
		set_run(1'b0);
		set_run(1'b1);
		frame(test);
	endtask

	task automatic test_first_tick();
		blue_x = 5'd2;
		blue_y = 5'd2;
		blue_dir = trail_pkg::DIR_RIGHT;
		red_x = 5'd20;
		red_y = 5'd20;
		red_dir = trail_pkg::DIR_DOWN;
		set_run(1'b1);
		frame("first_tick");
		frame("first_tick");
	endtask

	task automatic test_straight();
		trail_pkg::coord_t rx;
		trail_pkg::coord_t ry;
		rand_coord(blue_x);
		rand_coord(blue_y);
		blue_dir = trail_pkg::DIR_RIGHT;
		rand_coord(rx);
		rand_coord(ry);
		red_x = rx;
		red_y = ry;
		red_dir = trail_pkg::DIR_DOWN;
		restart("straight");
		for (int i = 0; i < 2; i++)
		begin
			blue_x = blue_x + 5'd1;
			frame("straight_blue");
		end
		for (int i = 0; i < 2; i++)
		begin
			red_y = red_y + 5'd1;
			frame("straight_red");
		end
	endtask

	task automatic test_corner();
		blue_x = 5'd10;
		blue_y = 5'd12;
		blue_dir = trail_pkg::DIR_RIGHT;
		restart("corner");
		blue_x = 5'd11;
		frame("corner");
		blue_y = 5'd13;
		blue_dir = trail_pkg::DIR_DOWN;
		frame("corner");
	endtask

	task automatic test_both_players();
		blue_x = 5'd4;
		blue_y = 5'd5;
		blue_dir = trail_pkg::DIR_RIGHT;
		red_x = 5'd4;
		red_y = 5'd9;
		red_dir = trail_pkg::DIR_DOWN;
		restart("both_players");
		blue_x = 5'd5;
		red_y = 5'd10;
		frame("both_players");
	endtask

	task automatic test_collision();
		blue_x = 5'd8;
		blue_y = 5'd8;
		blue_dir = trail_pkg::DIR_RIGHT;
		red_x = 5'd9;
		red_y = 5'd6;
		red_dir = trail_pkg::DIR_DOWN;
		restart("collision");
		blue_x = 5'd9;
		red_y = 5'd7;
		frame("collision");
		blue_x = 5'd10;
		red_y = 5'd8;
		frame("collision");
		check_crash("collision", 1'b1, crash_red);
		check_crash("collision", 1'b0, crash_blue);
		// blue turns back onto its own trail
		blue_x = 5'd9;
		blue_dir = trail_pkg::DIR_LEFT;
		frame("collision");
		check_crash("collision", 1'b1, crash_blue);
	endtask

	task automatic test_run_clear();
		set_run(1'b0);
		check_crash("run_clear", 1'b0, crash_blue);
		check_crash("run_clear", 1'b0, crash_red);
		red_y = 5'd7;
		set_run(1'b1);
		frame("run_clear");
		red_y = 5'd8;
		frame("run_clear");
		check_crash("run_clear", 1'b0, crash_red);
		check_crash("run_clear", 1'b0, crash_blue);
	endtask

	initial
	begin
		#2_000_000;
		report_failure("simulation ran past its time limit");
	end

	initial
	begin
		lfsr = 8'd67;
		arst_n = 1'b0;
		run = 1'b0;
		frame_tick = 1'b0;
		blue_x = '0;
		blue_y = '0;
		blue_dir = trail_pkg::DIR_UP;
		red_x = '0;
		red_y = '0;
		red_dir = trail_pkg::DIR_UP;
		armed = 1'b0;
		exp_crash[0] = 1'b0;
		exp_crash[1] = 1'b0;
		foreach (occupied[i])
			occupied[i] = 1'b0;
		repeat (10) @(negedge Clk);
		arst_n = 1'b1;
		@(negedge Clk);
		if (fb_we !== 1'b0)
			report_failure("fb_we is not low after reset");
		check_crash("reset", 1'b0, crash_blue);
		check_crash("reset", 1'b0, crash_red);
		test_first_tick();
		test_straight();
		test_corner();
		test_both_players();
		test_collision();
		test_run_clear();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
